/* calu_defines.svh */
`ifndef CALU_DEFINES_SVH
`define CALU_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////////////////////
`define CALU_DATA_W   16 // one operand part, re or im
`define CALU_PROD_W   32 // one product / result part
`define CALU_SHIFT_W  4  // result shift field

// start to done inside the datapath
// two core stages plus the combine stage
`define CALU_LATENCY  3

////////////////////////////////////////////////////////////////////////////
// config register map
////////////////////////////////////////////////////////////////////////////
`define CALU_ADDR_OP     1'd0 // operation select
`define CALU_ADDR_SHIFT  1'd1 // output shift amount

`endif

/* calu_pkg.sv */
`default_nettype none
`include "calu_defines.svh"

package calu_pkg;

	// one complex operand, re in the upper half
	typedef struct packed {
		logic signed [`CALU_DATA_W-1:0] re; // real part
		logic signed [`CALU_DATA_W-1:0] im; // imaginary part
	} cplx_t;

	// one complex result, 64 bits total
	typedef struct packed {
		logic signed [`CALU_PROD_W-1:0] re; // real part
		logic signed [`CALU_PROD_W-1:0] im; // imaginary part
	} cres_t;

	typedef enum logic [1:0] {
		OP_CMUL      = 2'd0, // a * b
		OP_CMUL_CONJ = 2'd1, // a * conj(b)
		OP_CADD      = 2'd2, // a + b
		OP_MAG2      = 2'd3  // |a|^2
	} calu_op_e;

	// live configuration, sampled per transaction
	typedef struct packed {
		calu_op_e                  op;    // operation
		logic [`CALU_SHIFT_W-1:0]  shift; // arithmetic right shift
	} calu_cfg_t;

endpackage

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "calu_defines.svh"

// reduced multiply-add slice
// p = c +/- (a*b or sext(a)), two register stages
module alu (
	input  logic                           clk,
	input  logic                           reset_i,
	input  logic signed [`CALU_DATA_W-1:0] a_i,
	input  logic signed [`CALU_DATA_W-1:0] b_i,
	input  logic signed [`CALU_PROD_W-1:0] c_i,
	input  logic                           usemult_i, // 0: pass a through
	input  logic                           sub_i,     // 1: c minus term
	input  logic                           valid_i,
	output logic signed [`CALU_PROD_W-1:0] p_o,
	output logic                           valid_o
);

	logic signed [`CALU_DATA_W-1:0] a_q;
	logic signed [`CALU_DATA_W-1:0] b_q;
	logic signed [`CALU_PROD_W-1:0] c_q;
	logic                           usemult_q;
	logic                           sub_q;
	logic                           valid_q;   // stage 1 valid

	logic signed [`CALU_PROD_W-1:0] mult_w;    // full signed product
	logic signed [`CALU_PROD_W-1:0] term_w;    // product or sext(a)
	logic signed [`CALU_PROD_W-1:0] p_w;

	// input register stage
	always_ff @(posedge clk) begin
		a_q       <= a_i;
		b_q       <= b_i;
		c_q       <= c_i;
		usemult_q <= usemult_i;
		sub_q     <= sub_i;
	end

	assign mult_w = `CALU_PROD_W'(a_q) * `CALU_PROD_W'(b_q); // 16x16 fits in 32
	assign term_w = usemult_q ? mult_w : `CALU_PROD_W'(a_q);  // add mode, sign extended
	assign p_w    = sub_q ? (c_q - term_w) : (c_q + term_w);   // wraps mod 2^32

	// result register stage
	always_ff @(posedge clk) begin
		p_o <= p_w;
	end

	// valid travels with the data
	always_ff @(posedge clk) begin
		if (reset_i) begin
			valid_q <= 1'b0;
			valid_o <= 1'b0;
		end else begin
			valid_q <= valid_i;
			valid_o <= valid_q;
		end
	end

endmodule

`default_nettype wire

/* complex_alu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "calu_defines.svh"

module complex_alu (
	input  logic              clk,
	input  logic              reset_i,
	input  logic              start_i,
	input  calu_pkg::cplx_t   a_i,
	input  calu_pkg::cplx_t   b_i,
	input  calu_pkg::calu_cfg_t cfg_i,   // latched with the operands
	output logic              done_o,
	output calu_pkg::cres_t   result_o
);

	logic signed [`CALU_DATA_W-1:0] core_a [4];
	logic signed [`CALU_DATA_W-1:0] core_b [4];
	logic signed [`CALU_PROD_W-1:0] core_c [4];
	logic                           core_mult [4];
	logic signed [`CALU_PROD_W-1:0] core_p [4];
	logic [3:0]                     core_valid;

	calu_pkg::calu_cfg_t            cfg_pipe [`CALU_LATENCY-1]; // cfg per stage
	logic signed [`CALU_PROD_W-1:0] re_w;
	logic signed [`CALU_PROD_W-1:0] im_w;

	////////////////////////////////////////////////////////////////////////////
	// operand routing to the four cores
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			core_a[i]    = '0;
			core_b[i]    = '0;
			core_c[i]    = '0;
			core_mult[i] = 1'b1;
		end
		case (cfg_i.op)
			calu_pkg::OP_CMUL, calu_pkg::OP_CMUL_CONJ: begin
				core_a[0] = a_i.re; // ar*br
				core_b[0] = b_i.re;
				core_a[1] = a_i.im; // ai*bi
				core_b[1] = b_i.im;
				core_a[2] = a_i.re; // ar*bi
				core_b[2] = b_i.im;
				core_a[3] = a_i.im; // ai*br
				core_b[3] = b_i.re;
			end
			calu_pkg::OP_CADD: begin
				core_a[0]    = a_i.re;                   // ar + br
				core_c[0]    = `CALU_PROD_W'(b_i.re);
				core_mult[0] = 1'b0;
				core_a[2]    = a_i.im;                   // ai + bi
				core_c[2]    = `CALU_PROD_W'(b_i.im);
				core_mult[2] = 1'b0;
			end
			default: begin // OP_MAG2
				core_a[0] = a_i.re; // ar^2
				core_b[0] = a_i.re;
				core_a[1] = a_i.im; // ai^2
				core_b[1] = a_i.im;
			end
		endcase
	end

	alu core_1 (
		.clk       (clk),
		.reset_i   (reset_i),
		.a_i       (core_a[0]),
		.b_i       (core_b[0]),
		.c_i       (core_c[0]),
		.usemult_i (core_mult[0]),
		.sub_i     (1'b0), // signs are applied at the combine
		.valid_i   (start_i),
		.p_o       (core_p[0]),
		.valid_o   (core_valid[0])
	);

	alu core_2 (
		.clk       (clk),
		.reset_i   (reset_i),
		.a_i       (core_a[1]),
		.b_i       (core_b[1]),
		.c_i       (core_c[1]),
		.usemult_i (core_mult[1]),
		.sub_i     (1'b0),
		.valid_i   (start_i),
		.p_o       (core_p[1]),
		.valid_o   (core_valid[1])
	);

	alu core_3 (
		.clk       (clk),
		.reset_i   (reset_i),
		.a_i       (core_a[2]),
		.b_i       (core_b[2]),
		.c_i       (core_c[2]),
		.usemult_i (core_mult[2]),
		.sub_i     (1'b0),
		.valid_i   (start_i),
		.p_o       (core_p[2]),
		.valid_o   (core_valid[2])
	);

	alu core_4 (
		.clk       (clk),
		.reset_i   (reset_i),
		.a_i       (core_a[3]),
		.b_i       (core_b[3]),
		.c_i       (core_c[3]),
		.usemult_i (core_mult[3]),
		.sub_i     (1'b0),
		.valid_i   (start_i),
		.p_o       (core_p[3]),
		.valid_o   (core_valid[3])
	);

	// op and shift follow their item through the core stages
	always_ff @(posedge clk) begin
		cfg_pipe[0] <= cfg_i;
		for (int i = 1; i < `CALU_LATENCY-1; i++) begin
			cfg_pipe[i] <= cfg_pipe[i-1];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// combine and shift
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		case (cfg_pipe[`CALU_LATENCY-2].op)
			calu_pkg::OP_CMUL: begin
				re_w = core_p[0] - core_p[1]; // ar*br - ai*bi
				im_w = core_p[2] + core_p[3]; // ar*bi + ai*br
			end
			calu_pkg::OP_CMUL_CONJ: begin
				re_w = core_p[0] + core_p[1];
				im_w = core_p[3] - core_p[2]; // ai*br - ar*bi
			end
			calu_pkg::OP_CADD: begin
				re_w = core_p[0];
				im_w = core_p[2];
			end
			default: begin // |a|^2 is real
				re_w = core_p[0] + core_p[1];
				im_w = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		result_o.re <= re_w >>> cfg_pipe[`CALU_LATENCY-2].shift; // arithmetic
		result_o.im <= im_w >>> cfg_pipe[`CALU_LATENCY-2].shift;
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			done_o <= 1'b0;
		end else begin
			done_o <= &core_valid; // cores run in lockstep
		end
	end

endmodule

`default_nettype wire

/* calu_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "calu_defines.svh"

module calu_cfg_regs (
	input  logic                     clk,
	input  logic                     reset_i,
	input  logic                     cfg_we_i,
	input  logic                     cfg_addr_i,
	input  logic [`CALU_DATA_W-1:0]  cfg_wdata_i,
	output logic [`CALU_DATA_W-1:0]  cfg_rdata_o,
	output calu_pkg::calu_cfg_t      cfg_o
);

	calu_pkg::calu_cfg_t cfg_q;

	// write port, low field bits only
	always_ff @(posedge clk) begin
		if (reset_i) begin
			cfg_q.op    <= calu_pkg::OP_CMUL;
			cfg_q.shift <= '0;
		end else if (cfg_we_i) begin
			if (cfg_addr_i == `CALU_ADDR_OP) begin
				cfg_q.op <= calu_pkg::calu_op_e'(cfg_wdata_i[1:0]);
			end else begin
				cfg_q.shift <= cfg_wdata_i[`CALU_SHIFT_W-1:0];
			end
		end
	end

	// readback, upper bits zero
	always_comb begin
		if (cfg_addr_i == `CALU_ADDR_SHIFT) begin
			cfg_rdata_o = `CALU_DATA_W'(cfg_q.shift);
		end else begin
			cfg_rdata_o = `CALU_DATA_W'(cfg_q.op);
		end
	end

	assign cfg_o = cfg_q; // live copy, sampled at start

endmodule

`default_nettype wire

/* calu_req_ack.sv */
`timescale 1ns/1ps
`default_nettype none

module calu_req_ack (
	input  logic                clk,
	input  logic                reset_i,
	input  logic                req_i,
	input  calu_pkg::cplx_t     a_i,
	input  calu_pkg::cplx_t     b_i,
	input  calu_pkg::calu_cfg_t cfg_i,
	input  logic                done_i,
	input  calu_pkg::cres_t     result_i,
	output logic                ack_o,
	output logic                start_o,
	output calu_pkg::cplx_t     op_a_o,
	output calu_pkg::cplx_t     op_b_o,
	output calu_pkg::calu_cfg_t op_cfg_o,
	output calu_pkg::cres_t     result_o
);

	typedef enum logic [1:0] {
		S_IDLE,  // waiting for req
		S_BUSY,  // item in the datapath
		S_ACKED  // result held until req drops
	} state_e;

	state_e state_q;
	logic   launch_q; // capture done, start next cycle

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q  <= S_IDLE;
			launch_q <= 1'b0;
			start_o  <= 1'b0;
			ack_o    <= 1'b0;
		end else begin
			launch_q <= 1'b0;
			start_o  <= launch_q; // one cycle pulse
			case (state_q)
				S_IDLE: begin
					if (req_i) begin
						state_q  <= S_BUSY;
						launch_q <= 1'b1;
					end
				end
				S_BUSY: begin
					if (done_i) begin
						state_q <= S_ACKED;
						ack_o   <= 1'b1;
					end
				end
				S_ACKED: begin
					if (!req_i) begin // four-phase return to zero
						state_q <= S_IDLE;
						ack_o   <= 1'b0;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// operand / config capture and result hold
	always_ff @(posedge clk) begin
		if (state_q == S_IDLE && req_i) begin
			op_a_o   <= a_i;
			op_b_o   <= b_i;
			op_cfg_o <= cfg_i; // later cfg writes wait for next item
		end
		if (state_q == S_BUSY && done_i) begin
			result_o <= result_i;
		end
	end

endmodule

`default_nettype wire

/* complex_alu_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "calu_defines.svh"

module complex_alu_top (
	input  logic                    clk,
	input  logic                    reset_i,
	input  logic                    req_i,
	input  calu_pkg::cplx_t         a_i,
	input  calu_pkg::cplx_t         b_i,
	input  logic                    cfg_we_i,
	input  logic                    cfg_addr_i,
	input  logic [`CALU_DATA_W-1:0] cfg_wdata_i,
	output logic                    ack_o,
	output calu_pkg::cres_t         result_o,
	output logic [`CALU_DATA_W-1:0] cfg_rdata_o
);

	calu_pkg::calu_cfg_t cfg;      // live register value
	calu_pkg::calu_cfg_t op_cfg;   // per-transaction copy
	calu_pkg::cplx_t     op_a;
	calu_pkg::cplx_t     op_b;
	calu_pkg::cres_t     alu_result;
	logic                start;
	logic                done;

	calu_cfg_regs i_cfg_regs (
		.clk         (clk),
		.reset_i     (reset_i),
		.cfg_we_i    (cfg_we_i),
		.cfg_addr_i  (cfg_addr_i),
		.cfg_wdata_i (cfg_wdata_i),
		.cfg_rdata_o (cfg_rdata_o),
		.cfg_o       (cfg)
	);

	calu_req_ack i_req_ack (
		.clk      (clk),
		.reset_i  (reset_i),
		.req_i    (req_i),
		.a_i      (a_i),
		.b_i      (b_i),
		.cfg_i    (cfg),
		.done_i   (done),
		.result_i (alu_result),
		.ack_o    (ack_o),
		.start_o  (start),
		.op_a_o   (op_a),
		.op_b_o   (op_b),
		.op_cfg_o (op_cfg),
		.result_o (result_o)
	);

	complex_alu i_datapath (
		.clk      (clk),
		.reset_i  (reset_i),
		.start_i  (start),
		.a_i      (op_a),
		.b_i      (op_b),
		.cfg_i    (op_cfg),
		.done_o   (done),
		.result_o (alu_result)
	);

endmodule

`default_nettype wire

/* complex_alu_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "calu_defines.svh"

module complex_alu_tb;

	logic                    clk;
	logic                    reset_i;
	logic                    req_i;
	calu_pkg::cplx_t         a_i;
	calu_pkg::cplx_t         b_i;
	logic                    cfg_we_i;
	logic                    cfg_addr_i;
	logic [`CALU_DATA_W-1:0] cfg_wdata_i;
	logic                    ack_o;
	calu_pkg::cres_t         result_o;
	logic [`CALU_DATA_W-1:0] cfg_rdata_o;

	int              seed = 15;
	int              err_count = 0;
	int              check_count = 0;
	int              test_count = 0;
	int              err_mark;    // errors before the current test
	logic            ack_prev = 1'b0;
	calu_pkg::cres_t exp_q [$];   // expected results, oldest first
	calu_pkg::cres_t exp_now;

	complex_alu_top i_dut (
		.clk         (clk),
		.reset_i     (reset_i),
		.req_i       (req_i),
		.a_i         (a_i),
		.b_i         (b_i),
		.cfg_we_i    (cfg_we_i),
		.cfg_addr_i  (cfg_addr_i),
		.cfg_wdata_i (cfg_wdata_i),
		.ack_o       (ack_o),
		.result_o    (result_o),
		.cfg_rdata_o (cfg_rdata_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////
	function automatic calu_pkg::cres_t ref_result(calu_pkg::cplx_t a, calu_pkg::cplx_t b,
			calu_pkg::calu_op_e op, logic [`CALU_SHIFT_W-1:0] shift);
		int              ar;
		int              ai;
		int              br;
		int              bi;
		int              re;
		int              im;
		calu_pkg::cres_t r;
		ar = 32'(a.re); // sign extended
		ai = 32'(a.im);
		br = 32'(b.re);
		bi = 32'(b.im);
		case (op)
			calu_pkg::OP_CMUL: begin
				re = ar * br - ai * bi;
				im = ar * bi + ai * br;
			end
			calu_pkg::OP_CMUL_CONJ: begin
				re = ar * br + ai * bi;
				im = ai * br - ar * bi;
			end
			calu_pkg::OP_CADD: begin
				re = ar + br;
				im = ai + bi;
			end
			default: begin
				re = ar * ar + ai * ai;
				im = 0;
			end
		endcase
		r.re = re >>> shift; // int is signed, so arithmetic
		r.im = im >>> shift;
		return r;
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("Error at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// compares each result as ack rises
	always @(negedge clk) begin
		if (!reset_i && ack_o && !ack_prev) begin
			if (exp_q.size() == 0) begin
				err_count++;
				$display("ack rose at %0t ns with no request outstanding", $time);
			end else begin
				exp_now = exp_q.pop_front();
				check(result_o.re, exp_now.re, "result real part");
				check(result_o.im, exp_now.im, "result imaginary part");
			end
		end
		ack_prev = ack_o;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
		$display("Done: errors found");
		$finish;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// bus and handshake helpers, all start and end at a falling edge
	////////////////////////////////////////////////////////////////////////////
	task automatic wait_ack(input logic level, output int n, input string why);
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (ack_o !== level && n < 40); // timeout
		if (ack_o !== level) abort_run(why);
	endtask

	task automatic write_cfg(input logic addr, input logic [`CALU_DATA_W-1:0] data);
		cfg_we_i    = 1'b1;
		cfg_addr_i  = addr;
		cfg_wdata_i = data;
		@(negedge clk);
		cfg_we_i    = 1'b0;
	endtask

	task automatic read_cfg(input logic addr, output logic [`CALU_DATA_W-1:0] data);
		cfg_addr_i = addr;
		@(negedge clk);
		data = cfg_rdata_o; // combinational readback
	endtask

	task automatic set_cfg(input calu_pkg::calu_op_e op, input logic [`CALU_SHIFT_W-1:0] sh);
		write_cfg(`CALU_ADDR_OP, {14'd0, op});
		write_cfg(`CALU_ADDR_SHIFT, {12'd0, sh});
	endtask

	task automatic rand_cplx(output calu_pkg::cplx_t c);
		int r;
		r    = $random(seed);
		c.re = r[15:0];
		c.im = r[31:16];
	endtask

	task automatic do_txn(input calu_pkg::cplx_t a, input calu_pkg::cplx_t b,
			input calu_pkg::calu_op_e op, input logic [`CALU_SHIFT_W-1:0] sh);
		int n;
		exp_q.push_back(ref_result(a, b, op, sh));
		a_i   = a;
		b_i   = b;
		req_i = 1'b1;
		wait_ack(1'b1, n, "ack never rose");
		req_i = 1'b0; // return to zero
		wait_ack(1'b0, n, "ack never fell after req dropped");
	endtask

	task automatic random_txns(input int count, input calu_pkg::calu_op_e op,
			input logic [`CALU_SHIFT_W-1:0] sh);
		calu_pkg::cplx_t a;
		calu_pkg::cplx_t b;
		for (int k = 0; k < count; k++) begin
			rand_cplx(a);
			rand_cplx(b);
			do_txn(a, b, op, sh);
		end
	endtask

	task automatic start_test();
		err_mark = err_count;
	endtask

	task automatic finish_test(input string name);
		test_count++;
		$display("test %-34s %s", name, (err_count == err_mark) ? "pass" : "FAIL");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		logic [`CALU_DATA_W-1:0] rd;
		calu_pkg::cplx_t         a;
		calu_pkg::cplx_t         b;
		calu_pkg::cres_t         held;
		int                      n;
		int                      sh_list [3];
		reset_i     = 1'b1;
		req_i       = 1'b0;
		a_i         = '0;
		b_i         = '0;
		cfg_we_i    = 1'b0;
		cfg_addr_i  = 1'b0;
		cfg_wdata_i = '0;
		sh_list     = '{1, 7, 15};
		repeat (2) @(negedge clk);
		reset_i = 1'b0;

		start_test();
		read_cfg(`CALU_ADDR_OP, rd);
		check({16'd0, rd}, 32'h0, "op after reset");
		read_cfg(`CALU_ADDR_SHIFT, rd);
		check({16'd0, rd}, 32'h0, "shift after reset");
		write_cfg(`CALU_ADDR_OP, 16'hFFFF);
		write_cfg(`CALU_ADDR_SHIFT, 16'h00F9);
		read_cfg(`CALU_ADDR_OP, rd);
		check({16'd0, rd}, 32'h3, "op readback masked");
		read_cfg(`CALU_ADDR_SHIFT, rd);
		check({16'd0, rd}, 32'h9, "shift readback masked");
		finish_test("config reset and readback");

		start_test();
		set_cfg(calu_pkg::OP_CMUL, 4'd0);
		a = {16'h8000, 16'h8000}; // most negative parts
		do_txn(a, a, calu_pkg::OP_CMUL, 4'd0);
		rand_cplx(b);
		do_txn('0, b, calu_pkg::OP_CMUL, 4'd0);
		random_txns(18, calu_pkg::OP_CMUL, 4'd0);
		finish_test("complex multiply");

		start_test();
		set_cfg(calu_pkg::OP_CMUL_CONJ, 4'd0);
		random_txns(10, calu_pkg::OP_CMUL_CONJ, 4'd0);
		set_cfg(calu_pkg::OP_CADD, 4'd0);
		random_txns(10, calu_pkg::OP_CADD, 4'd0);
		set_cfg(calu_pkg::OP_MAG2, 4'd0);
		random_txns(10, calu_pkg::OP_MAG2, 4'd0);
		finish_test("conjugate, add and magnitude");

		start_test();
		for (int k = 0; k < 3; k++) begin
			set_cfg(calu_pkg::OP_CMUL, sh_list[k][3:0]);
			do_txn({16'hFED4, 16'd5}, {16'd7, 16'd2}, calu_pkg::OP_CMUL, sh_list[k][3:0]);
			do_txn({16'd300, 16'd5}, {16'd7, 16'd2}, calu_pkg::OP_CMUL, sh_list[k][3:0]);
			random_txns(2, calu_pkg::OP_CMUL, sh_list[k][3:0]);
		end
		finish_test("arithmetic shift");

		start_test();
		set_cfg(calu_pkg::OP_CMUL, 4'd0);
		for (int k = 0; k < 5; k++) begin
			@(negedge clk);
			check({31'd0, ack_o}, 32'h0, "ack before request");
		end
		rand_cplx(a);
		rand_cplx(b);
		exp_q.push_back(ref_result(a, b, calu_pkg::OP_CMUL, 4'd0));
		a_i   = a;
		b_i   = b;
		req_i = 1'b1;
		wait_ack(1'b1, n, "ack never rose");
		check(n - 1, `CALU_LATENCY + 2, "cycles from req to ack");
		held = result_o;
		for (int k = 0; k < 10; k++) begin
			@(negedge clk);
			check(result_o.re, held.re, "held real part");
			check(result_o.im, held.im, "held imaginary part");
			check({31'd0, ack_o}, 32'h1, "ack held with req");
		end
		req_i = 1'b0;
		wait_ack(1'b0, n, "ack never fell after req dropped");
		check(n, 1, "cycles from req low to ack low");
		finish_test("handshake protocol");

		start_test();
		rand_cplx(a);
		rand_cplx(b);
		exp_q.push_back(ref_result(a, b, calu_pkg::OP_CMUL, 4'd0));
		a_i   = a;
		b_i   = b;
		req_i = 1'b1;
		@(negedge clk);
		write_cfg(`CALU_ADDR_OP, 16'h0002); // add, while item in flight
		wait_ack(1'b1, n, "ack never rose");
		req_i = 1'b0;
		wait_ack(1'b0, n, "ack never fell after req dropped");
		do_txn(a, b, calu_pkg::OP_CADD, 4'd0); // next one sees the write
		finish_test("config write mid-transaction");

		@(negedge clk);
		if (exp_q.size() != 0) begin
			err_count++;
			$display("%0d expected results were never returned", exp_q.size());
		end
		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
		if (err_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
calu_pkg.sv
alu.sv
complex_alu.sv
calu_cfg_regs.sv
calu_req_ack.sv
complex_alu_top.sv
complex_alu_tb.sv

/* Makefile */
TOP = complex_alu_tb

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): sources.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing -f sources.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
